// File: logic/cv_bus_pkg.sv
/*
 * Console bus glue package
 * Bus widths, controller mode encoding and the memory/I/O map codes
 */

package cv_bus_pkg;

  // ------------------------------------------------------------
  // Bus and memory widths
  // ------------------------------------------------------------

  // Z80 address and data
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t;

  // 8 KiB BIOS ROM
  typedef logic [12:0] bios_addr_t;

  // 1 KiB RAM, mirrored across its 8 KiB window
  typedef logic [9:0]  ram_addr_t;

  // 32 KiB cartridge space
  typedef logic [14:0] cart_addr_t;

  // One controller pin, bit 0 player 1, bit 1 player 2
  typedef logic [1:0]  ctrl_pins_t;

  // Controller latch state, selects keypad or joystick strobe
  typedef enum logic {
    CTRL_MODE_KEY = 1'b0,
    CTRL_MODE_JOY = 1'b1
  } ctrl_mode_e;

  // ------------------------------------------------------------
  // Constants
  // ------------------------------------------------------------

  // Idle bus reads back as all ones
  localparam data_t DATA_INACTIVE = 8'hFF;

  // 10.7 MHz enables per CPU enable (3.58 MHz)
  localparam int CLK_DIV_CPU = 3;
  localparam int CLK_DIV_W   = $clog2(CLK_DIV_CPU);

  // I/O groups on A7..A5
  localparam logic [2:0] IO_GRP_KEY = 3'b100;
  localparam logic [2:0] IO_GRP_VDP = 3'b101;
  localparam logic [2:0] IO_GRP_JOY = 3'b110;
  localparam logic [2:0] IO_GRP_PSG = 3'b111;

  // Memory regions on A15..A13
  localparam logic [2:0] MEM_REG_BIOS = 3'b000;
  localparam logic [2:0] MEM_REG_RAM  = 3'b011;

endpackage

// File: logic/cv_addr_decode.sv
/*
 * Address decoder
 * Splits CPU cycles into memory and I/O and drives active-low
 * chip enables and strobes for every device on the bus
 */

`timescale 1ns/1ns

module cv_addr_decode
  import cv_bus_pkg::*;
(
  input  addr_t a_i,
  input  logic  mreq_n_i,
  input  logic  iorq_n_i,
  input  logic  rd_n_i,
  input  logic  wr_n_i,
  input  logic  m1_n_i,
  input  logic  rfsh_n_i,
  output logic  bios_ce_n_o,
  output logic  ram_ce_n_o,
  output logic  cart_en_80_n_o,
  output logic  cart_en_a0_n_o,
  output logic  cart_en_c0_n_o,
  output logic  cart_en_e0_n_o,
  output logic  vdp_r_n_o,
  output logic  vdp_w_n_o,
  output logic  psg_we_n_o,
  output logic  ctrl_r_n_o,
  output logic  key_wr_n_o,
  output logic  joy_wr_n_o
);

  // Refresh cycles also pull mreq, keep them off the memories
  logic       mem_cyc_s;
  // Interrupt acknowledge has iorq and m1 low together
  logic       io_cyc_s;
  logic [2:0] mem_reg_s;
  logic [2:0] io_grp_s;
  logic [5:0] mem_en_n_s;

  assign mem_cyc_s = ~mreq_n_i & rfsh_n_i;
  assign io_cyc_s  = ~iorq_n_i & m1_n_i;
  assign mem_reg_s = a_i[15:13];
  assign io_grp_s  = a_i[7:5];

  always_comb
  begin
    bios_ce_n_o    = 1'b1;
    ram_ce_n_o     = 1'b1;
    cart_en_80_n_o = 1'b1;
    cart_en_a0_n_o = 1'b1;
    cart_en_c0_n_o = 1'b1;
    cart_en_e0_n_o = 1'b1;
    vdp_r_n_o      = 1'b1;
    vdp_w_n_o      = 1'b1;
    psg_we_n_o     = 1'b1;
    ctrl_r_n_o     = 1'b1;
    key_wr_n_o     = 1'b1;
    joy_wr_n_o     = 1'b1;

    // ------------------------------------------------------------
    // Memory map, 8 KiB regions
    // ------------------------------------------------------------
    if (mem_cyc_s)
    begin
      if (mem_reg_s == MEM_REG_BIOS)
        bios_ce_n_o = 1'b0;
      if (mem_reg_s == MEM_REG_RAM)
        ram_ce_n_o = 1'b0;
      // Upper 32 KiB is cartridge, one enable per 8 KiB
      if (a_i[15])
      begin
        case (a_i[14:13])
          2'b00:   cart_en_80_n_o = 1'b0;
          2'b01:   cart_en_a0_n_o = 1'b0;
          2'b10:   cart_en_c0_n_o = 1'b0;
          default: cart_en_e0_n_o = 1'b0;
        endcase
      end
    end

    // ------------------------------------------------------------
    // I/O map, only A7..A5 decoded
    // ------------------------------------------------------------
    if (io_cyc_s)
    begin
      case (io_grp_s)
        IO_GRP_KEY: key_wr_n_o = wr_n_i;
        IO_GRP_JOY: joy_wr_n_o = wr_n_i;
        IO_GRP_VDP:
        begin
          vdp_r_n_o = rd_n_i;
          vdp_w_n_o = wr_n_i;
        end
        IO_GRP_PSG:
        begin
          // PSG is write only, reads here hit the controllers
          psg_we_n_o = wr_n_i;
          ctrl_r_n_o = rd_n_i;
        end
        default: ;
      endcase
    end
  end

  assign mem_en_n_s = {bios_ce_n_o, ram_ce_n_o, cart_en_80_n_o,
                       cart_en_a0_n_o, cart_en_c0_n_o, cart_en_e0_n_o};

  // Overlapping regions would fight on the read mux
  a_mem_onehot: assert property (@(mem_en_n_s) $onehot0(~mem_en_n_s))
    else $error("more than one memory enable active");

endmodule

// File: logic/cv_cpu_timing.sv
/*
 * CPU timing
 * Divides the 10.7 MHz enable down to the CPU enable and inserts
 * one wait state per M1 cycle, merged with the PSG ready level
 */

`timescale 1ns/1ns

module cv_cpu_timing
  import cv_bus_pkg::*;
(
  input  logic clk_i,
  input  logic reset_n_i,
  input  logic clk_en_10m7_i,
  input  logic m1_n_i,
  input  logic psg_ready_i,
  output logic clk_en_cpu_o,
  output logic wait_n_o
);

  logic                 reset_n_s;
  logic [CLK_DIV_W-1:0] div_cnt_q;
  logic                 div_last_s;
  logic                 m1_wait_q;
  logic                 m1_wait_clr_n_s;

  assign reset_n_s = reset_n_i;

  // ------------------------------------------------------------
  // Clock enable divider
  // ------------------------------------------------------------

  // Counts 10.7 MHz pulses, wraps on the last one
  assign div_last_s = (div_cnt_q == CLK_DIV_W'(CLK_DIV_CPU - 1));

  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
      div_cnt_q <= '0;
    else if (clk_en_10m7_i)
    begin
      if (div_last_s)
        div_cnt_q <= '0;
      else
        div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // Every third pulse, first one is the third after reset
  assign clk_en_cpu_o = clk_en_10m7_i & div_last_s;

  // ------------------------------------------------------------
  // M1 wait flop
  // ------------------------------------------------------------

  // Held clear outside M1 and in reset
  assign m1_wait_clr_n_s = reset_n_s & ~m1_n_i;

  always_ff @(posedge clk_i or negedge m1_wait_clr_n_s)
  begin
    if (!m1_wait_clr_n_s)
      m1_wait_q <= 1'b0;
    else if (clk_en_cpu_o)
      m1_wait_q <= ~m1_wait_q;
  end

  // PSG holds the CPU while it latches a write
  assign wait_n_o = psg_ready_i & ~m1_wait_q;

  // Back-to-back enables would run the CPU at the full 10.7 MHz
  a_cpu_en_gap: assert property (@(posedge clk_i) disable iff (!reset_n_s)
    clk_en_cpu_o |=> !clk_en_cpu_o)
    else $error("CPU enable high on consecutive cycles");

endmodule

// File: logic/cv_ctrl_port.sv
/*
 * Controller port
 * Keypad/joystick mode latch, select pin drive and the controller
 * read byte for the player chosen by A1
 */

`timescale 1ns/1ns

module cv_ctrl_port
  import cv_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_n_i,
  input  logic       clk_en_cpu_i,
  input  logic       key_wr_n_i,
  input  logic       joy_wr_n_i,
  input  logic       a1_i,
  input  ctrl_pins_t ctrl_p1_i,
  input  ctrl_pins_t ctrl_p2_i,
  input  ctrl_pins_t ctrl_p3_i,
  input  ctrl_pins_t ctrl_p4_i,
  input  ctrl_pins_t ctrl_p6_i,
  output ctrl_pins_t ctrl_p5_o,
  output ctrl_pins_t ctrl_p8_o,
  output data_t      d_o
);

  logic       reset_n_s;
  ctrl_mode_e mode_q;

  assign reset_n_s = reset_n_i;

  // ------------------------------------------------------------
  // Mode latch
  // ------------------------------------------------------------

  // Any write to the group sets the mode, data is ignored
  always_ff @(posedge clk_i or negedge reset_n_s)
  begin
    if (!reset_n_s)
      mode_q <= CTRL_MODE_KEY;
    else if (clk_en_cpu_i)
    begin
      if (!key_wr_n_i)
        mode_q <= CTRL_MODE_KEY;
      else if (!joy_wr_n_i)
        mode_q <= CTRL_MODE_JOY;
    end
  end

  // Common line of the selected matrix pulled low on both pads
  assign ctrl_p5_o = (mode_q == CTRL_MODE_KEY) ? 2'b00 : 2'b11;
  assign ctrl_p8_o = (mode_q == CTRL_MODE_JOY) ? 2'b00 : 2'b11;

  // ------------------------------------------------------------
  // Read byte
  // ------------------------------------------------------------

  // A1 low is player 1 (bit 0), high is player 2
  // Fire on bit 6, unused bits read high
  assign d_o = {1'b1,
                ctrl_p6_i[a1_i],
                2'b11,
                ctrl_p4_i[a1_i],
                ctrl_p3_i[a1_i],
                ctrl_p2_i[a1_i],
                ctrl_p1_i[a1_i]};

  // Decoder keeps the two write groups apart
  a_wr_excl: assert property (@(posedge clk_i) disable iff (!reset_n_s)
    !(!key_wr_n_i && !joy_wr_n_i))
    else $error("keypad and joystick strobes low together");

endmodule

// File: logic/cv_read_mux.sv
/*
 * Read data multiplexer
 * Masks each source with its enable and ANDs the result onto the
 * CPU data bus
 */

`timescale 1ns/1ns

module cv_read_mux
  import cv_bus_pkg::*;
(
  input  logic  bios_ce_n_i,
  input  logic  ram_ce_n_i,
  input  logic  cart_ce_n_i,
  input  logic  vdp_r_n_i,
  input  logic  ctrl_r_n_i,
  input  data_t bios_d_i,
  input  data_t ram_d_i,
  input  data_t cart_d_i,
  input  data_t vdp_d_i,
  input  data_t ctrl_d_i,
  output data_t d_o
);

  data_t bios_m_s;
  data_t ram_m_s;
  data_t cart_m_s;
  data_t vdp_m_s;
  data_t ctrl_m_s;

  // Disabled sources float high like the open bus
  always_comb
  begin
    bios_m_s = DATA_INACTIVE;
    ram_m_s  = DATA_INACTIVE;
    cart_m_s = DATA_INACTIVE;
    vdp_m_s  = DATA_INACTIVE;
    ctrl_m_s = DATA_INACTIVE;

    if (!bios_ce_n_i)
      bios_m_s = bios_d_i;
    if (!ram_ce_n_i)
      ram_m_s = ram_d_i;
    if (!cart_ce_n_i)
      cart_m_s = cart_d_i;
    if (!vdp_r_n_i)
      vdp_m_s = vdp_d_i;
    if (!ctrl_r_n_i)
      ctrl_m_s = ctrl_d_i;
  end

  // Wired-AND of all sources
  assign d_o = bios_m_s & ram_m_s & cart_m_s & vdp_m_s & ctrl_m_s;

endmodule

// File: logic/cv_console_bus.sv
/*
 * Console bus glue, top level
 * Connects address decoder, CPU timing, controller port and read
 * mux between the Z80 bus and the external chips
 */

`timescale 1ns/1ns

module cv_console_bus
  import cv_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_n_i,
  input  logic       clk_en_10m7_i,
  // CPU bus
  input  addr_t      a_i,
  input  data_t      d_i,
  input  logic       mreq_n_i,
  input  logic       iorq_n_i,
  input  logic       rd_n_i,
  input  logic       wr_n_i,
  input  logic       m1_n_i,
  input  logic       rfsh_n_i,
  input  logic       psg_ready_i,
  // Read data from the devices
  input  data_t      bios_rom_d_i,
  input  data_t      ram_d_i,
  input  data_t      cart_d_i,
  input  data_t      vdp_d_i,
  // Controllers
  input  ctrl_pins_t ctrl_p1_i,
  input  ctrl_pins_t ctrl_p2_i,
  input  ctrl_pins_t ctrl_p3_i,
  input  ctrl_pins_t ctrl_p4_i,
  input  ctrl_pins_t ctrl_p6_i,
  // BIOS ROM and RAM
  output bios_addr_t bios_rom_a_o,
  output logic       bios_rom_ce_n_o,
  output ram_addr_t  ram_a_o,
  output logic       ram_ce_n_o,
  output logic       ram_we_n_o,
  output logic       ram_rd_n_o,
  output data_t      ram_d_o,
  // Cartridge
  output cart_addr_t cart_a_o,
  output logic       cart_en_80_n_o,
  output logic       cart_en_a0_n_o,
  output logic       cart_en_c0_n_o,
  output logic       cart_en_e0_n_o,
  output logic       cart_rd_o,
  // VDP, PSG, controller selects
  output logic       vdp_csr_n_o,
  output logic       vdp_csw_n_o,
  output logic       vdp_mode_o,
  output logic       psg_we_n_o,
  output ctrl_pins_t ctrl_p5_o,
  output ctrl_pins_t ctrl_p8_o,
  // CPU side
  output logic       clk_en_cpu_o,
  output logic       wait_n_o,
  output data_t      d_o
);

  logic  reset_n_s;
  logic  cart_ce_n_s;
  logic  ctrl_r_n_s;
  logic  key_wr_n_s;
  logic  joy_wr_n_s;
  data_t ctrl_d_s;

  assign reset_n_s = reset_n_i;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  cv_addr_decode i_cv_addr_decode (
    .a_i(a_i),                       .mreq_n_i(mreq_n_i),
    .iorq_n_i(iorq_n_i),             .rd_n_i(rd_n_i),
    .wr_n_i(wr_n_i),                 .m1_n_i(m1_n_i),
    .rfsh_n_i(rfsh_n_i),             .bios_ce_n_o(bios_rom_ce_n_o),
    .ram_ce_n_o(ram_ce_n_o),         .cart_en_80_n_o(cart_en_80_n_o),
    .cart_en_a0_n_o(cart_en_a0_n_o), .cart_en_c0_n_o(cart_en_c0_n_o),
    .cart_en_e0_n_o(cart_en_e0_n_o), .vdp_r_n_o(vdp_csr_n_o),
    .vdp_w_n_o(vdp_csw_n_o),         .psg_we_n_o(psg_we_n_o),
    .ctrl_r_n_o(ctrl_r_n_s),         .key_wr_n_o(key_wr_n_s),
    .joy_wr_n_o(joy_wr_n_s)
  );

  // ------------------------------------------------------------
  // Execute
  // ------------------------------------------------------------
  cv_cpu_timing i_cv_cpu_timing (
    .clk_i(clk_i),                   .reset_n_i(reset_n_s),
    .clk_en_10m7_i(clk_en_10m7_i),   .m1_n_i(m1_n_i),
    .psg_ready_i(psg_ready_i),       .clk_en_cpu_o(clk_en_cpu_o),
    .wait_n_o(wait_n_o)
  );

  cv_ctrl_port i_cv_ctrl_port (
    .clk_i(clk_i),                   .reset_n_i(reset_n_s),
    .clk_en_cpu_i(clk_en_cpu_o),     .key_wr_n_i(key_wr_n_s),
    .joy_wr_n_i(joy_wr_n_s),         .a1_i(a_i[1]),
    .ctrl_p1_i(ctrl_p1_i),           .ctrl_p2_i(ctrl_p2_i),
    .ctrl_p3_i(ctrl_p3_i),           .ctrl_p4_i(ctrl_p4_i),
    .ctrl_p6_i(ctrl_p6_i),           .ctrl_p5_o(ctrl_p5_o),
    .ctrl_p8_o(ctrl_p8_o),           .d_o(ctrl_d_s)
  );

  // ------------------------------------------------------------
  // Result
  // ------------------------------------------------------------

  // Any cart region selects the slot
  assign cart_ce_n_s = cart_en_80_n_o & cart_en_a0_n_o & cart_en_c0_n_o & cart_en_e0_n_o;
  assign cart_rd_o   = ~cart_ce_n_s;

  cv_read_mux i_cv_read_mux (
    .bios_ce_n_i(bios_rom_ce_n_o),   .ram_ce_n_i(ram_ce_n_o),
    .cart_ce_n_i(cart_ce_n_s),       .vdp_r_n_i(vdp_csr_n_o),
    .ctrl_r_n_i(ctrl_r_n_s),         .bios_d_i(bios_rom_d_i),
    .ram_d_i(ram_d_i),               .cart_d_i(cart_d_i),
    .vdp_d_i(vdp_d_i),               .ctrl_d_i(ctrl_d_s),
    .d_o(d_o)
  );

  // Address slices, RAM mirrors every 1 KiB
  assign bios_rom_a_o = a_i[12:0];
  assign ram_a_o      = a_i[9:0];
  assign cart_a_o     = a_i[14:0];
  // A0 picks VDP data or control port
  assign vdp_mode_o   = a_i[0];

  assign ram_d_o    = d_i;
  assign ram_we_n_o = wr_n_i;
  assign ram_rd_n_o = rd_n_i;

endmodule

// File: verification/cv_console_bus_vectors.svh
/*
 * Console bus test vectors
 * Bus cycle codes, vector record and the decode/read path table
 */

`ifndef CV_CONSOLE_BUS_VECTORS_SVH
`define CV_CONSOLE_BUS_VECTORS_SVH

// ------------------------------------------------------------
// Bus cycle codes {mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n}
// ------------------------------------------------------------
localparam logic [5:0] CYC_IDLE     = 6'b111111;
localparam logic [5:0] CYC_MEM_RD   = 6'b010111;
localparam logic [5:0] CYC_FETCH    = 6'b010101;
localparam logic [5:0] CYC_MEM_WR   = 6'b011011;
localparam logic [5:0] CYC_RFSH     = 6'b011110;
localparam logic [5:0] CYC_IO_RD    = 6'b100111;
localparam logic [5:0] CYC_IO_WR    = 6'b101011;
// I/O with m1 low, as in interrupt acknowledge
localparam logic [5:0] CYC_IO_RD_M1 = 6'b100101;
localparam logic [5:0] CYC_IO_WR_M1 = 6'b101001;

// Expected enables, active low
// {bios, ram, c80, ca0, cc0, ce0, vdp_r, vdp_w, psg_we}
localparam logic [8:0] EN_NONE  = 9'h1FF;
localparam logic [8:0] EN_BIOS  = 9'h0FF;
localparam logic [8:0] EN_RAM   = 9'h17F;
localparam logic [8:0] EN_C80   = 9'h1BF;
localparam logic [8:0] EN_CA0   = 9'h1DF;
localparam logic [8:0] EN_CC0   = 9'h1EF;
localparam logic [8:0] EN_CE0   = 9'h1F7;
localparam logic [8:0] EN_VDP_R = 9'h1FB;
localparam logic [8:0] EN_VDP_W = 9'h1FD;
localparam logic [8:0] EN_PSG_W = 9'h1FE;

// Source expected on d_o
localparam logic [2:0] SRC_NONE = 3'd0;
localparam logic [2:0] SRC_BIOS = 3'd1;
localparam logic [2:0] SRC_RAM  = 3'd2;
localparam logic [2:0] SRC_CART = 3'd3;
localparam logic [2:0] SRC_VDP  = 3'd4;
localparam logic [2:0] SRC_CTRL = 3'd5;

// Controller pins {p6, p4, p3, p2, p1}, two players each
localparam logic [9:0] PINS_OFF = 10'b00_00_00_00_00;
localparam logic [9:0] PINS_A   = 10'b10_01_10_01_10;
localparam logic [9:0] PINS_B   = 10'b01_11_00_10_01;

localparam int NUM_VEC = 24;

typedef struct packed {
  addr_t      a;
  logic [5:0] cyc;
  ctrl_pins_t p6;
  ctrl_pins_t p4;
  ctrl_pins_t p3;
  ctrl_pins_t p2;
  ctrl_pins_t p1;
  logic [8:0] en_n;
  logic [2:0] src;
} vec_t;

vec_t vec_table [NUM_VEC];
int   vec_cnt = 0;

task automatic add_row(input addr_t a, input logic [5:0] cyc, input logic [9:0] pins,
                       input logic [8:0] en_n, input logic [2:0] src);
  vec_t row;
  row.a    = a;
  row.cyc  = cyc;
  {row.p6, row.p4, row.p3, row.p2, row.p1} = pins;
  row.en_n = en_n;
  row.src  = src;
  vec_table[vec_cnt] = row;
  vec_cnt++;
endtask

task automatic load_vectors();
  add_row(16'h0000, CYC_IDLE,     PINS_OFF, EN_NONE,  SRC_NONE);
  add_row(16'h0123, CYC_MEM_RD,   PINS_OFF, EN_BIOS,  SRC_BIOS);
  add_row(16'h1ffe, CYC_FETCH,    PINS_OFF, EN_BIOS,  SRC_BIOS);
  // Unmapped regions 001 and 010
  add_row(16'h2000, CYC_MEM_RD,   PINS_OFF, EN_NONE,  SRC_NONE);
  add_row(16'h5abc, CYC_MEM_RD,   PINS_OFF, EN_NONE,  SRC_NONE);
  add_row(16'h6000, CYC_MEM_RD,   PINS_OFF, EN_RAM,   SRC_RAM);
  add_row(16'h7c55, CYC_MEM_RD,   PINS_OFF, EN_RAM,   SRC_RAM);
  // Mux masks by enable only, RAM still drives on a write
  add_row(16'h6010, CYC_MEM_WR,   PINS_OFF, EN_RAM,   SRC_RAM);
  add_row(16'h6000, CYC_RFSH,     PINS_OFF, EN_NONE,  SRC_NONE);
  add_row(16'h8000, CYC_MEM_RD,   PINS_OFF, EN_C80,   SRC_CART);
  add_row(16'ha5a5, CYC_MEM_RD,   PINS_OFF, EN_CA0,   SRC_CART);
  add_row(16'hc321, CYC_MEM_RD,   PINS_OFF, EN_CC0,   SRC_CART);
  add_row(16'hffff, CYC_MEM_RD,   PINS_OFF, EN_CE0,   SRC_CART);
  add_row(16'h00be, CYC_IO_RD,    PINS_OFF, EN_VDP_R, SRC_VDP);
  add_row(16'h00bf, CYC_IO_WR,    PINS_OFF, EN_VDP_W, SRC_NONE);
  add_row(16'h00a1, CYC_IO_RD_M1, PINS_OFF, EN_NONE,  SRC_NONE);
  add_row(16'h00ff, CYC_IO_WR,    PINS_OFF, EN_PSG_W, SRC_NONE);
  // Controller reads, A1 picks the player
  add_row(16'h00fc, CYC_IO_RD,    PINS_A,   EN_NONE,  SRC_CTRL);
  add_row(16'h00fe, CYC_IO_RD,    PINS_A,   EN_NONE,  SRC_CTRL);
  add_row(16'h00fd, CYC_IO_RD,    PINS_B,   EN_NONE,  SRC_CTRL);
  add_row(16'h00fc, CYC_IO_RD_M1, PINS_A,   EN_NONE,  SRC_NONE);
  add_row(16'h00ff, CYC_IO_WR_M1, PINS_OFF, EN_NONE,  SRC_NONE);
  add_row(16'h0010, CYC_IO_RD,    PINS_OFF, EN_NONE,  SRC_NONE);
  // Memory cycle whose low byte looks like the VDP group
  add_row(16'h20bf, CYC_MEM_RD,   PINS_OFF, EN_NONE,  SRC_NONE);
endtask

`endif

// File: verification/tb_cv_console_bus.sv
/*
 * Console bus testbench
 * Table-driven decode and read path checks, then timed checks of the
 * controller latch, CPU enable divider and wait states
 */

`timescale 1ns/1ns

module tb_cv_console_bus
  import cv_bus_pkg::*;
();

  // Cycles per CPU enable with the 10.7 MHz enable held high
  localparam int CPU_PERIOD = 3;
  localparam int WAIT_LIMIT = 20;

  logic       clk_i;
  logic       reset_n_i;
  logic       clk_en_10m7_i;
  addr_t      a_i;
  data_t      d_i;
  logic       mreq_n_i;
  logic       iorq_n_i;
  logic       rd_n_i;
  logic       wr_n_i;
  logic       m1_n_i;
  logic       rfsh_n_i;
  logic       psg_ready_i;
  data_t      bios_rom_d_i;
  data_t      ram_d_i;
  data_t      cart_d_i;
  data_t      vdp_d_i;
  ctrl_pins_t ctrl_p1_i;
  ctrl_pins_t ctrl_p2_i;
  ctrl_pins_t ctrl_p3_i;
  ctrl_pins_t ctrl_p4_i;
  ctrl_pins_t ctrl_p6_i;
  bios_addr_t bios_rom_a_o;
  logic       bios_rom_ce_n_o;
  ram_addr_t  ram_a_o;
  logic       ram_ce_n_o;
  logic       ram_we_n_o;
  logic       ram_rd_n_o;
  data_t      ram_d_o;
  cart_addr_t cart_a_o;
  logic       cart_en_80_n_o;
  logic       cart_en_a0_n_o;
  logic       cart_en_c0_n_o;
  logic       cart_en_e0_n_o;
  logic       cart_rd_o;
  logic       vdp_csr_n_o;
  logic       vdp_csw_n_o;
  logic       vdp_mode_o;
  logic       psg_we_n_o;
  ctrl_pins_t ctrl_p5_o;
  ctrl_pins_t ctrl_p8_o;
  logic       clk_en_cpu_o;
  logic       wait_n_o;
  data_t      d_o;
  integer     seed;

  `include "cv_console_bus_vectors.svh"

  cv_console_bus i_cv_console_bus (
    .clk_i(clk_i),                     .reset_n_i(reset_n_i),
    .clk_en_10m7_i(clk_en_10m7_i),     .a_i(a_i),
    .d_i(d_i),                         .mreq_n_i(mreq_n_i),
    .iorq_n_i(iorq_n_i),               .rd_n_i(rd_n_i),
    .wr_n_i(wr_n_i),                   .m1_n_i(m1_n_i),
    .rfsh_n_i(rfsh_n_i),               .psg_ready_i(psg_ready_i),
    .bios_rom_d_i(bios_rom_d_i),       .ram_d_i(ram_d_i),
    .cart_d_i(cart_d_i),               .vdp_d_i(vdp_d_i),
    .ctrl_p1_i(ctrl_p1_i),             .ctrl_p2_i(ctrl_p2_i),
    .ctrl_p3_i(ctrl_p3_i),             .ctrl_p4_i(ctrl_p4_i),
    .ctrl_p6_i(ctrl_p6_i),             .bios_rom_a_o(bios_rom_a_o),
    .bios_rom_ce_n_o(bios_rom_ce_n_o), .ram_a_o(ram_a_o),
    .ram_ce_n_o(ram_ce_n_o),           .ram_we_n_o(ram_we_n_o),
    .ram_rd_n_o(ram_rd_n_o),           .ram_d_o(ram_d_o),
    .cart_a_o(cart_a_o),               .cart_en_80_n_o(cart_en_80_n_o),
    .cart_en_a0_n_o(cart_en_a0_n_o),   .cart_en_c0_n_o(cart_en_c0_n_o),
    .cart_en_e0_n_o(cart_en_e0_n_o),   .cart_rd_o(cart_rd_o),
    .vdp_csr_n_o(vdp_csr_n_o),         .vdp_csw_n_o(vdp_csw_n_o),
    .vdp_mode_o(vdp_mode_o),           .psg_we_n_o(psg_we_n_o),
    .ctrl_p5_o(ctrl_p5_o),             .ctrl_p8_o(ctrl_p8_o),
    .clk_en_cpu_o(clk_en_cpu_o),       .wait_n_o(wait_n_o),
    .d_o(d_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Compare and stop helpers
  // ------------------------------------------------------------
  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic timeout_stop(input string what);
    $display("Timeout after %0d cycles waiting for %s at %0t", WAIT_LIMIT, what, $time);
    abort_run();
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp)
    begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_strobe(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pins(input string name, input ctrl_pins_t exp, input ctrl_pins_t act);
    if (act !== exp)
    begin
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bios_addr(input string name, input bios_addr_t exp,
                                 input bios_addr_t act);
    if (act !== exp)
    begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_ram_addr(input string name, input ram_addr_t exp,
                                input ram_addr_t act);
    if (act !== exp)
    begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cart_addr(input string name, input cart_addr_t exp,
                                 input cart_addr_t act);
    if (act !== exp)
    begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  function automatic data_t rand_byte();
    integer r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic drive_bus(input addr_t a, input logic [5:0] cyc);
    a_i = a;
    {mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i} = cyc;
  endtask

  // Controller byte: bit 7 one, bit 6 fire, bits 5..4 one, p4..p1 low
  function automatic data_t ctrl_byte(input vec_t row);
    logic  pl;
    data_t b;
    pl   = row.a[1];
    b    = 8'hFF;
    b[6] = row.p6[pl];
    b[3] = row.p4[pl];
    b[2] = row.p3[pl];
    b[1] = row.p2[pl];
    b[0] = row.p1[pl];
    return b;
  endfunction

  task automatic drive_row(input vec_t row);
    drive_bus(row.a, row.cyc);
    d_i          = rand_byte();
    bios_rom_d_i = rand_byte();
    ram_d_i      = rand_byte();
    cart_d_i     = rand_byte();
    vdp_d_i      = rand_byte();
    ctrl_p1_i    = row.p1;
    ctrl_p2_i    = row.p2;
    ctrl_p3_i    = row.p3;
    ctrl_p4_i    = row.p4;
    ctrl_p6_i    = row.p6;
  endtask

  task automatic check_row(input vec_t row);
    data_t exp_d;
    case (row.src)
      SRC_BIOS: exp_d = bios_rom_d_i;
      SRC_RAM:  exp_d = ram_d_i;
      SRC_CART: exp_d = cart_d_i;
      SRC_VDP:  exp_d = vdp_d_i;
      SRC_CTRL: exp_d = ctrl_byte(row);
      default:  exp_d = DATA_INACTIVE;
    endcase
    check_strobe("bios_rom_ce_n_o", row.en_n[8], bios_rom_ce_n_o);
    check_strobe("ram_ce_n_o", row.en_n[7], ram_ce_n_o);
    check_strobe("cart_en_80_n_o", row.en_n[6], cart_en_80_n_o);
    check_strobe("cart_en_a0_n_o", row.en_n[5], cart_en_a0_n_o);
    check_strobe("cart_en_c0_n_o", row.en_n[4], cart_en_c0_n_o);
    check_strobe("cart_en_e0_n_o", row.en_n[3], cart_en_e0_n_o);
    check_strobe("cart_rd_o", ~&row.en_n[6:3], cart_rd_o);
    check_strobe("vdp_csr_n_o", row.en_n[2], vdp_csr_n_o);
    check_strobe("vdp_csw_n_o", row.en_n[1], vdp_csw_n_o);
    check_strobe("psg_we_n_o", row.en_n[0], psg_we_n_o);
    check_strobe("vdp_mode_o", row.a[0], vdp_mode_o);
    check_strobe("ram_rd_n_o", row.cyc[3], ram_rd_n_o);
    check_strobe("ram_we_n_o", row.cyc[2], ram_we_n_o);
    // 8 KiB BIOS, 1 KiB RAM mirror, 32 KiB cartridge
    check_bios_addr("bios_rom_a_o", row.a[12:0], bios_rom_a_o);
    check_ram_addr("ram_a_o", row.a[9:0], ram_a_o);
    check_cart_addr("cart_a_o", row.a[14:0], cart_a_o);
    check_data("ram_d_o", d_i, ram_d_o);
    check_data("d_o", exp_d, d_o);
  endtask

  // Entered at a falling edge, returns at the falling edge of an enable cycle
  task automatic wait_cpu_en();
    int n;
    n = 0;
    while (clk_en_cpu_o !== 1'b1)
    begin
      if (n >= WAIT_LIMIT)
        timeout_stop("the CPU clock enable");
      @(negedge clk_i);
      n++;
    end
  endtask

  // ------------------------------------------------------------
  // Test sequences
  // ------------------------------------------------------------
  task automatic verify_reset_state();
    check_pins("ctrl_p5_o", 2'b00, ctrl_p5_o);
    check_pins("ctrl_p8_o", 2'b11, ctrl_p8_o);
    check_strobe("wait_n_o", 1'b1, wait_n_o);
    check_row(vec_table[0]);
    // First CPU enable comes with the third 10.7 MHz pulse
    check_strobe("clk_en_cpu_o", 1'b0, clk_en_cpu_o);
    @(negedge clk_i);
    check_strobe("clk_en_cpu_o", 1'b0, clk_en_cpu_o);
    @(negedge clk_i);
    check_strobe("clk_en_cpu_o", 1'b1, clk_en_cpu_o);
  endtask

  task automatic run_vector_table();
    int i;
    for (i = 0; i < NUM_VEC; i++)
    begin
      @(posedge clk_i);
      #5;
      drive_row(vec_table[i]);
      @(negedge clk_i);
      check_row(vec_table[i]);
    end
  endtask

  task automatic switch_ctrl_mode(input addr_t a, input ctrl_mode_e mode);
    ctrl_pins_t p5_new;
    ctrl_pins_t p8_new;
    int         n;
    // Keypad mode pulls p5 low, joystick mode pulls p8 low
    p5_new = (mode == CTRL_MODE_KEY) ? 2'b00 : 2'b11;
    p8_new = ~p5_new;
    @(posedge clk_i);
    #5;
    drive_bus(a, CYC_IO_WR);
    @(negedge clk_i);
    // Old mode holds up to and through the CPU enable cycle
    n = 0;
    check_pins("ctrl_p5_o", ~p5_new, ctrl_p5_o);
    check_pins("ctrl_p8_o", ~p8_new, ctrl_p8_o);
    while (clk_en_cpu_o !== 1'b1)
    begin
      if (n >= WAIT_LIMIT)
        timeout_stop("the CPU clock enable");
      @(negedge clk_i);
      n++;
      check_pins("ctrl_p5_o", ~p5_new, ctrl_p5_o);
      check_pins("ctrl_p8_o", ~p8_new, ctrl_p8_o);
    end
    @(posedge clk_i);
    #5;
    drive_bus(16'h0000, CYC_IDLE);
    @(negedge clk_i);
    check_pins("ctrl_p5_o", p5_new, ctrl_p5_o);
    check_pins("ctrl_p8_o", p8_new, ctrl_p8_o);
  endtask

  task automatic measure_cpu_period();
    int n;
    int k;
    wait_cpu_en();
    for (k = 0; k < 3; k++)
    begin
      @(negedge clk_i);
      n = 1;
      while (clk_en_cpu_o !== 1'b1)
      begin
        if (n >= WAIT_LIMIT)
          timeout_stop("the next CPU clock enable");
        @(negedge clk_i);
        n++;
      end
      if (n != CPU_PERIOD)
      begin
        $display("FAIL %0t clk_en_cpu_o period expected %0d actual %0d",
                 $time, CPU_PERIOD, n);
        abort_run();
      end
    end
  endtask

  // No 10.7 MHz pulses, no CPU enables
  task automatic hold_enable_off();
    @(posedge clk_i);
    #5;
    clk_en_10m7_i = 1'b0;
    repeat (2 * CPU_PERIOD)
    begin
      @(negedge clk_i);
      check_strobe("clk_en_cpu_o", 1'b0, clk_en_cpu_o);
    end
    @(posedge clk_i);
    #5;
    clk_en_10m7_i = 1'b1;
    @(negedge clk_i);
  endtask

  task automatic measure_m1_wait();
    int n;
    int low;
    wait_cpu_en();
    @(posedge clk_i);
    #5;
    drive_bus(16'h0000, CYC_FETCH);
    @(negedge clk_i);
    n = 0;
    // No wait before the first CPU enable of the M1 cycle
    while (clk_en_cpu_o !== 1'b1)
    begin
      check_strobe("wait_n_o", 1'b1, wait_n_o);
      if (n >= WAIT_LIMIT)
        timeout_stop("a CPU enable during M1");
      @(negedge clk_i);
      n++;
    end
    check_strobe("wait_n_o", 1'b1, wait_n_o);
    @(negedge clk_i);
    low = 0;
    while (wait_n_o !== 1'b1)
    begin
      if (low >= WAIT_LIMIT)
        timeout_stop("the end of the M1 wait state");
      low++;
      @(negedge clk_i);
    end
    if (low != CPU_PERIOD)
    begin
      $display("FAIL %0t wait_n_o low cycles expected %0d actual %0d",
               $time, CPU_PERIOD, low);
      abort_run();
    end
    @(posedge clk_i);
    #5;
    drive_bus(16'h0000, CYC_IDLE);
    @(negedge clk_i);
  endtask

  // PSG busy holds the CPU across several enables
  task automatic hold_psg_busy();
    @(posedge clk_i);
    #5;
    psg_ready_i = 1'b0;
    repeat (2 * CPU_PERIOD + 1)
    begin
      @(negedge clk_i);
      check_strobe("wait_n_o", 1'b0, wait_n_o);
    end
    @(posedge clk_i);
    #5;
    psg_ready_i = 1'b1;
    @(negedge clk_i);
    check_strobe("wait_n_o", 1'b1, wait_n_o);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial
  begin
    seed          = 32'h50ba6ec0;
    reset_n_i     = 1'b0;
    clk_en_10m7_i = 1'b1;
    drive_bus(16'h0000, CYC_IDLE);
    d_i           = 8'h00;
    psg_ready_i   = 1'b1;
    bios_rom_d_i  = 8'h00;
    ram_d_i       = 8'h00;
    cart_d_i      = 8'h00;
    vdp_d_i       = 8'h00;
    ctrl_p1_i     = 2'b11;
    ctrl_p2_i     = 2'b11;
    ctrl_p3_i     = 2'b11;
    ctrl_p4_i     = 2'b11;
    ctrl_p6_i     = 2'b11;
    load_vectors();

    repeat (5) @(posedge clk_i);
    #5;
    reset_n_i = 1'b1;
    @(negedge clk_i);

    verify_reset_state();
    run_vector_table();
    switch_ctrl_mode(16'h00c0, CTRL_MODE_JOY);
    switch_ctrl_mode(16'h0080, CTRL_MODE_KEY);
    measure_cpu_period();
    hold_enable_off();
    measure_m1_wait();
    hold_psg_busy();

    $display("All tests passed");
    $finish;
  end

endmodule

// File: cv_console_bus.f
+incdir+verification
logic/cv_bus_pkg.sv
logic/cv_addr_decode.sv
logic/cv_cpu_timing.sv
logic/cv_ctrl_port.sv
logic/cv_read_mux.sv
logic/cv_console_bus.sv
verification/tb_cv_console_bus.sv

// File: Bender.yml
package:
  name: cv_console_bus

sources:
  - files:
      - logic/cv_bus_pkg.sv
      - logic/cv_addr_decode.sv
      - logic/cv_cpu_timing.sv
      - logic/cv_ctrl_port.sv
      - logic/cv_read_mux.sv
      - logic/cv_console_bus.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_cv_console_bus.sv
